// ==== verilog/bm_pkg.sv ====
package bm_pkg;

	// ------------------------------
	// sizes
	// ------------------------------

	localparam int BUF_NUM = 32; // buffers in the pool.
	localparam int BUF_PTR_NBITS = 5; // buffer id and event counter width.
	localparam int BUF_CNT_NBITS = 6; // wide enough to count 0 to BUF_NUM.
	localparam int PIO_NBITS = 32;
	localparam int BM_REG_ADDR_NBITS = 3;
	localparam int ALPHA_NBITS = 4;

	// the threshold is free_count * alpha / 4, so alpha 4 means a factor of one.
	localparam int DT_SHIFT = 2;

	// ------------------------------
	// encodings
	// ------------------------------

	typedef enum logic [BM_REG_ADDR_NBITS-1:0] {
		BM_FREEB_INIT     = 3'd0,
		BM_FREEB_RD_COUNT = 3'd1,
		BM_FREEB_WR_COUNT = 3'd2,
		BM_LL_RD_COUNT    = 3'd3,
		BM_LL_WR_COUNT    = 3'd4,
		BM_DT_ALPHA       = 3'd5
	} bm_reg_addr_e;

	typedef enum logic {
		BM_OP_ALLOC   = 1'b0,
		BM_OP_RELEASE = 1'b1
	} bm_op_e;

	// LINK pops a buffer and appends it, UNLINK removes the head and pushes it back.
	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		LINK   = 2'd1,
		UNLINK = 2'd2
	} bm_alloc_state_e;

	// ------------------------------
	// client port
	// ------------------------------

	typedef struct packed {
		logic   valid;
		bm_op_e op;
	} bm_cmd_t;

	typedef struct packed {
		logic                     valid;
		bm_op_e                   op;
		logic                     granted;
		logic [BUF_PTR_NBITS-1:0] buf_id; // zero when not granted.
	} bm_resp_t;

endpackage

// ==== verilog/bm_reg.sv ====
`timescale 1ns/1ps

module bm_reg
	import bm_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   clk_div,
	input  logic                   reg_bs,
	input  logic                   reg_rd,
	input  logic                   reg_wr,
	input  logic [PIO_NBITS-1:0]   reg_addr,
	input  logic [PIO_NBITS-1:0]   reg_din,
	input  logic                   freeb_init_done,
	input  logic                   inc_freeb_rd_count,
	input  logic                   inc_freeb_wr_count,
	input  logic                   inc_ll_rd_count,
	input  logic                   inc_ll_wr_count,
	output logic                   pio_ack,
	output logic                   pio_rvalid,
	output logic [PIO_NBITS-1:0]   pio_rdata,
	output logic                   freeb_init,
	output logic [ALPHA_NBITS-1:0] dt_alpha
);

	logic pio_pend; // a request was seen and is waiting for a slow-bus cycle.
	logic addr_hit;
	logic sel_freeb_init;
	logic sel_dt_alpha;
	logic wr_freeb_init;
	logic wr_dt_alpha;

	logic [BUF_PTR_NBITS-1:0] freeb_rd_count;
	logic [BUF_PTR_NBITS-1:0] freeb_wr_count;
	logic [BUF_PTR_NBITS-1:0] ll_rd_count;
	logic [BUF_PTR_NBITS-1:0] ll_wr_count;

	assign wr_freeb_init = reg_bs & reg_wr & sel_freeb_init;
	assign wr_dt_alpha = reg_bs & reg_wr & sel_dt_alpha;

	// ------------------------------
	// address decode and read data
	// ------------------------------

	always_comb begin
		addr_hit = 1'b0;
		sel_freeb_init = 1'b0;
		sel_dt_alpha = 1'b0;
		pio_rdata = '0;
		case (bm_reg_addr_e'(reg_addr[BM_REG_ADDR_NBITS-1:0]))
			BM_FREEB_INIT: begin
				addr_hit = 1'b1;
				sel_freeb_init = 1'b1;
				pio_rdata = {freeb_init_done, {(PIO_NBITS-2){1'b0}}, freeb_init};
			end
			BM_FREEB_RD_COUNT: begin
				addr_hit = 1'b1;
				pio_rdata = PIO_NBITS'(freeb_rd_count);
			end
			BM_FREEB_WR_COUNT: begin
				addr_hit = 1'b1;
				pio_rdata = PIO_NBITS'(freeb_wr_count);
			end
			BM_LL_RD_COUNT: begin
				addr_hit = 1'b1;
				pio_rdata = PIO_NBITS'(ll_rd_count);
			end
			BM_LL_WR_COUNT: begin
				addr_hit = 1'b1;
				pio_rdata = PIO_NBITS'(ll_wr_count);
			end
			BM_DT_ALPHA: begin
				addr_hit = 1'b1;
				sel_dt_alpha = 1'b1;
				pio_rdata = PIO_NBITS'(dt_alpha);
			end
			default: ; // addresses 6 and 7 are not decoded.
		endcase
	end

	// ------------------------------
	// handshake
	// ------------------------------

	// the acknowledge only moves on cycles qualified by clk_div.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pio_pend <= 1'b0;
			pio_ack <= 1'b0;
			pio_rvalid <= 1'b0;
		end else begin
			if (reg_bs & (reg_rd | reg_wr))
				pio_pend <= 1'b1;
			else if (clk_div)
				pio_pend <= 1'b0;
			if (clk_div) begin
				pio_ack <= pio_pend;
				pio_rvalid <= pio_pend & addr_hit; // reg_addr is still held here.
			end
		end
	end

	// ------------------------------
	// control and event counters
	// ------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			freeb_init <= 1'b0;
			dt_alpha <= '0;
			freeb_rd_count <= '0;
			freeb_wr_count <= '0;
			ll_rd_count <= '0;
			ll_wr_count <= '0;
		end else begin
			freeb_init <= wr_freeb_init & reg_din[0]; // one-cycle pulse.
			if (wr_dt_alpha)
				dt_alpha <= reg_din[ALPHA_NBITS-1:0];
			// the counters wrap at 32.
			if (inc_freeb_rd_count)
				freeb_rd_count <= freeb_rd_count + 1'b1;
			if (inc_freeb_wr_count)
				freeb_wr_count <= freeb_wr_count + 1'b1;
			if (inc_ll_rd_count)
				ll_rd_count <= ll_rd_count + 1'b1;
			if (inc_ll_wr_count)
				ll_wr_count <= ll_wr_count + 1'b1;
		end
	end

	// an acknowledge answers only a request whose select the master still holds.
	a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(pio_ack) |-> $past(reg_bs) && $past(reg_bs, 2))
		else $error("pio_ack rose without a held request");

endmodule

// ==== verilog/bm_freeb.sv ====
`timescale 1ns/1ps

module bm_freeb
	import bm_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     init,
	input  logic                     pop,
	input  logic                     push,
	input  logic [BUF_PTR_NBITS-1:0] push_id,
	output logic [BUF_PTR_NBITS-1:0] top_id,
	output logic [BUF_CNT_NBITS-1:0] free_count,
	output logic                     init_done
);

	logic [BUF_PTR_NBITS-1:0] stack_mem [BUF_NUM];
	logic [BUF_CNT_NBITS-1:0] sp; // number of ids on the stack.
	logic [BUF_PTR_NBITS-1:0] top_idx;
	logic                     filling;
	logic [BUF_PTR_NBITS-1:0] fill_id;
	logic                     fill_last;

	assign top_idx = BUF_PTR_NBITS'(sp - 1'b1);
	assign top_id = stack_mem[top_idx]; // only meaningful while sp is nonzero.
	assign free_count = sp;
	assign fill_last = (fill_id == BUF_PTR_NBITS'(BUF_NUM - 1));

	// ------------------------------
	// stack pointer and init fill
	// ------------------------------

	// init restarts the fill from id 0, and the fill blocks pop and push.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sp <= '0;
			filling <= 1'b0;
			fill_id <= '0;
			init_done <= 1'b0;
		end else if (init) begin
			sp <= '0;
			filling <= 1'b1;
			fill_id <= '0;
			init_done <= 1'b0;
		end else if (filling) begin
			sp <= BUF_CNT_NBITS'(fill_id) + 1'b1;
			fill_id <= fill_id + 1'b1;
			if (fill_last) begin
				filling <= 1'b0;
				init_done <= 1'b1; // the last id, 31, ends up on top.
			end
		end else if (pop) begin
			sp <= sp - 1'b1;
		end else if (push) begin
			sp <= sp + 1'b1;
		end
	end

	// ------------------------------
	// id storage
	// ------------------------------

	always_ff @(posedge clk) begin
		if (!init) begin
			if (filling)
				stack_mem[fill_id] <= fill_id;
			else if (push && !pop)
				stack_mem[sp[BUF_PTR_NBITS-1:0]] <= push_id;
		end
	end

	// the controller must respect the stack bounds it sees through free_count.
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		pop && !filling |-> sp != '0)
		else $error("pop from an empty free stack");

	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		push && !filling |-> sp != BUF_CNT_NBITS'(BUF_NUM))
		else $error("push onto a full free stack");

endmodule

// ==== verilog/bm_ll.sv ====
`timescale 1ns/1ps

module bm_ll
	import bm_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     clear,
	input  logic                     link_wr,
	input  logic [BUF_PTR_NBITS-1:0] wr_id,
	input  logic                     link_rd,
	output logic [BUF_PTR_NBITS-1:0] head_id,
	output logic [BUF_CNT_NBITS-1:0] q_len
);

	logic [BUF_PTR_NBITS-1:0] next_mem [BUF_NUM]; // next pointer of each buffer.
	logic [BUF_PTR_NBITS-1:0] head_q;
	logic [BUF_PTR_NBITS-1:0] tail_q;
	logic [BUF_CNT_NBITS-1:0] len_q;

	assign head_id = head_q;
	assign q_len = len_q;

	// ------------------------------
	// head, tail and length
	// ------------------------------

	// link_wr and link_rd never come together, the controller does one per command.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head_q <= '0;
			tail_q <= '0;
			len_q <= '0;
		end else if (clear) begin
			head_q <= '0;
			tail_q <= '0;
			len_q <= '0;
		end else if (link_wr) begin
			tail_q <= wr_id;
			if (len_q == '0)
				head_q <= wr_id; // the first buffer is both head and tail.
			len_q <= len_q + 1'b1;
		end else if (link_rd) begin
			head_q <= next_mem[head_q];
			len_q <= len_q - 1'b1;
		end
	end

	// ------------------------------
	// next-pointer memory
	// ------------------------------

	// an append to an empty queue writes a stale tail entry that nothing reads.
	always_ff @(posedge clk) begin
		if (link_wr && !clear)
			next_mem[tail_q] <= wr_id;
	end

endmodule

// ==== verilog/bm_alloc.sv ====
`timescale 1ns/1ps

module bm_alloc
	import bm_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  bm_cmd_t                  cmd,
	input  logic [ALPHA_NBITS-1:0]   dt_alpha,
	input  logic [BUF_PTR_NBITS-1:0] top_id,
	input  logic [BUF_CNT_NBITS-1:0] free_count,
	input  logic                     init_done,
	input  logic [BUF_PTR_NBITS-1:0] head_id,
	input  logic [BUF_CNT_NBITS-1:0] q_len,
	output logic                     cmd_ready,
	output bm_resp_t                 resp,
	output logic                     pop,
	output logic                     push,
	output logic [BUF_PTR_NBITS-1:0] push_id,
	output logic                     link_wr,
	output logic [BUF_PTR_NBITS-1:0] wr_id,
	output logic                     link_rd
);

	localparam int PROD_NBITS = BUF_CNT_NBITS + ALPHA_NBITS;

	bm_alloc_state_e state_q;
	logic            grant_q; // decision taken in IDLE, carried out in the next state.
	logic            accept;
	logic            admit;
	logic [PROD_NBITS-1:0] dt_prod;
	logic [PROD_NBITS-1:0] dt_thresh;

	logic                     resp_valid_q;
	bm_op_e                   resp_op_q;
	logic                     resp_granted_q;
	logic [BUF_PTR_NBITS-1:0] resp_id_q;

	assign cmd_ready = (state_q == IDLE) && init_done;
	assign accept = cmd.valid && cmd_ready;

	// ------------------------------
	// dynamic threshold
	// ------------------------------

	assign dt_prod = free_count * dt_alpha;
	assign dt_thresh = dt_prod >> DT_SHIFT; // truncates the fraction.
	assign admit = (free_count != '0) && (PROD_NBITS'(q_len) < dt_thresh);

	// ------------------------------
	// sequencing
	// ------------------------------

	assign pop = (state_q == LINK) && grant_q;
	assign link_wr = pop; // the popped id is appended in the same cycle.
	assign wr_id = top_id;
	assign push = (state_q == UNLINK) && grant_q;
	assign link_rd = push;
	assign push_id = head_id;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
			grant_q <= 1'b0;
			resp_valid_q <= 1'b0;
		end else begin
			resp_valid_q <= (state_q != IDLE);
			case (state_q)
				IDLE: begin
					if (accept) begin
						if (cmd.op == BM_OP_ALLOC) begin
							grant_q <= admit;
							state_q <= LINK;
						end else begin
							grant_q <= (q_len != '0);
							state_q <= UNLINK;
						end
					end
				end
				LINK, UNLINK: state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q != IDLE) begin
			resp_op_q <= (state_q == UNLINK) ? BM_OP_RELEASE : BM_OP_ALLOC;
			resp_granted_q <= grant_q;
			if (!grant_q)
				resp_id_q <= '0;
			else
				resp_id_q <= (state_q == LINK) ? top_id : head_id;
		end
	end

	assign resp = '{valid: resp_valid_q, op: resp_op_q, granted: resp_granted_q,
		buf_id: resp_id_q};

	// every accepted command gets exactly one response, two cycles later.
	a_resp_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
		accept |-> ##2 resp.valid)
		else $error("no response two cycles after acceptance");

	a_resp_has_cmd: assert property (@(posedge clk) disable iff (!rst_n)
		resp.valid |-> $past(accept, 2))
		else $error("response without a command two cycles earlier");

endmodule

// ==== verilog/bm_top.sv ====
`timescale 1ns/1ps

module bm_top
	import bm_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 clk_div,
	input  logic                 reg_bs,
	input  logic                 reg_rd,
	input  logic                 reg_wr,
	input  logic [PIO_NBITS-1:0] reg_addr,
	input  logic [PIO_NBITS-1:0] reg_din,
	output logic                 pio_ack,
	output logic                 pio_rvalid,
	output logic [PIO_NBITS-1:0] pio_rdata,
	input  bm_cmd_t              cmd,
	output logic                 cmd_ready,
	output bm_resp_t             resp
);

	logic                     freeb_init;
	logic                     init_done;
	logic [ALPHA_NBITS-1:0]   dt_alpha;
	logic                     pop;
	logic                     push;
	logic [BUF_PTR_NBITS-1:0] push_id;
	logic [BUF_PTR_NBITS-1:0] top_id;
	logic [BUF_CNT_NBITS-1:0] free_count;
	logic                     link_wr;
	logic                     link_rd;
	logic [BUF_PTR_NBITS-1:0] wr_id;
	logic [BUF_PTR_NBITS-1:0] head_id;
	logic [BUF_CNT_NBITS-1:0] q_len;

	bm_reg bm_reg_i (
		.clk(clk), .rst_n(rst_n), .clk_div(clk_div),
		.reg_bs(reg_bs), .reg_rd(reg_rd), .reg_wr(reg_wr),
		.reg_addr(reg_addr), .reg_din(reg_din),
		.freeb_init_done(init_done),
		.inc_freeb_rd_count(pop), .inc_freeb_wr_count(push), // fill pushes stay inside bm_freeb.
		.inc_ll_rd_count(link_rd), .inc_ll_wr_count(link_wr),
		.pio_ack(pio_ack), .pio_rvalid(pio_rvalid), .pio_rdata(pio_rdata),
		.freeb_init(freeb_init), .dt_alpha(dt_alpha)
	);

	bm_freeb bm_freeb_i (
		.clk(clk), .rst_n(rst_n), .init(freeb_init),
		.pop(pop), .push(push), .push_id(push_id),
		.top_id(top_id), .free_count(free_count), .init_done(init_done)
	);

	// the init pulse empties the queue while the free stack refills.
	bm_ll bm_ll_i (
		.clk(clk), .rst_n(rst_n), .clear(freeb_init),
		.link_wr(link_wr), .wr_id(wr_id), .link_rd(link_rd),
		.head_id(head_id), .q_len(q_len)
	);

	bm_alloc bm_alloc_i (
		.clk(clk), .rst_n(rst_n), .cmd(cmd), .dt_alpha(dt_alpha),
		.top_id(top_id), .free_count(free_count), .init_done(init_done),
		.head_id(head_id), .q_len(q_len),
		.cmd_ready(cmd_ready), .resp(resp),
		.pop(pop), .push(push), .push_id(push_id),
		.link_wr(link_wr), .wr_id(wr_id), .link_rd(link_rd)
	);

endmodule

// ==== dv/tb_bm.sv ====
`timescale 1ns/1ps

module tb_bm
	import bm_pkg::*;
();

	// the tests take about 1400 cycles, so this leaves twice the margin.
	localparam int CYCLE_LIMIT = 3000;
	localparam int INIT_CYCLES = 40; // longest wait for init_done after the init write.

	logic                 clk;
	logic                 rst_n;
	logic                 clk_div;
	logic                 reg_bs;
	logic                 reg_rd;
	logic                 reg_wr;
	logic [PIO_NBITS-1:0] reg_addr;
	logic [PIO_NBITS-1:0] reg_din;
	logic                 pio_ack;
	logic                 pio_rvalid;
	logic [PIO_NBITS-1:0] pio_rdata;
	bm_cmd_t              cmd;
	logic                 cmd_ready;
	bm_resp_t             resp;

	// model of the buffer manager.
	logic [BUF_PTR_NBITS-1:0] free_stack [$]; // the back is the top of the stack.
	logic [BUF_PTR_NBITS-1:0] model_q [$];
	int  alpha = 0;
	int  n_pop = 0, n_push = 0, n_link_wr = 0, n_link_rd = 0;
	logic model_init_done = 1'b0;

	// expectations that the assertions compare against.
	bm_resp_t             exp_resp = '0;
	logic                 resp_open = 1'b0;
	logic [PIO_NBITS-1:0] exp_rdata = '0;
	logic [PIO_NBITS-1:0] exp_mask = '0;
	logic                 exp_rvalid = 1'b0;
	logic                 rd_open = 1'b0;
	logic                 init_started = 1'b0;
	logic                 div_slow = 1'b0;

	int cycle_count = 0;
	int n_tests = 0, n_checks = 0, n_errors = 0, test_err_start = 0;
	logic [15:0] lfsr = 16'd15;

	bm_top bm_top_i (
		.clk(clk), .rst_n(rst_n), .clk_div(clk_div),
		.reg_bs(reg_bs), .reg_rd(reg_rd), .reg_wr(reg_wr),
		.reg_addr(reg_addr), .reg_din(reg_din),
		.pio_ack(pio_ack), .pio_rvalid(pio_rvalid), .pio_rdata(pio_rdata),
		.cmd(cmd), .cmd_ready(cmd_ready), .resp(resp)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// clk_div is high every cycle, or on every third cycle in the slow-bus test.
	initial begin
		int phase;
		phase = 0;
		clk_div = 1'b1;
		forever begin
			@(posedge clk);
			#1;
			phase = (phase + 1) % 3;
			clk_div = div_slow ? (phase == 0) : 1'b1;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ------------------------------
	// checks
	// ------------------------------

	function automatic void report_mismatch(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		n_errors++;
	endfunction

	a_resp_match: assert property (@(posedge clk) disable iff (!rst_n)
		resp.valid |-> resp_open && resp == exp_resp)
		else report_mismatch($sformatf("resp %h, expected %h", resp, exp_resp));

	a_read_match: assert property (@(posedge clk) disable iff (!rst_n)
		pio_ack && rd_open |-> pio_rvalid == exp_rvalid &&
			(pio_rdata & exp_mask) == (exp_rdata & exp_mask))
		else report_mismatch($sformatf("read %h rvalid %b, expected %h rvalid %b",
			pio_rdata, pio_rvalid, exp_rdata, exp_rvalid));

	a_no_ready_before_init: assert property (@(posedge clk) disable iff (!rst_n)
		!init_started |-> !cmd_ready)
		else report_mismatch("cmd_ready high before init");

	a_ack_on_div: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(pio_ack) |-> $past(clk_div))
		else report_mismatch("pio_ack rose after a cycle with clk_div low");

	// ------------------------------
	// stimulus helpers
	// ------------------------------

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	// galois form of x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		if (state[0])
			return (state >> 1) ^ 16'hB400;
		return state >> 1;
	endfunction

	task automatic pio_access(input logic wr, input logic [BM_REG_ADDR_NBITS-1:0] addr,
			input logic [PIO_NBITS-1:0] din, output logic [PIO_NBITS-1:0] data);
		reg_addr = PIO_NBITS'(addr);
		reg_din = din;
		reg_bs = 1'b1;
		reg_rd = !wr;
		reg_wr = wr;
		step();
		reg_rd = 1'b0; // the strobe lasts one cycle, reg_bs stays until the ack.
		reg_wr = 1'b0;
		while (!pio_ack)
			step();
		data = pio_rdata;
		reg_bs = 1'b0;
		while (pio_ack)
			step();
	endtask

	task automatic read_reg(input logic [BM_REG_ADDR_NBITS-1:0] addr,
			input logic [PIO_NBITS-1:0] exp, input logic [PIO_NBITS-1:0] mask,
			input logic rvalid, output logic [PIO_NBITS-1:0] data);
		exp_rdata = exp;
		exp_mask = mask;
		exp_rvalid = rvalid;
		rd_open = 1'b1;
		n_checks++;
		pio_access(1'b0, addr, '0, data);
		rd_open = 1'b0;
	endtask

	task automatic write_alpha(input int value);
		logic [PIO_NBITS-1:0] data;
		alpha = value;
		pio_access(1'b1, BM_DT_ALPHA, PIO_NBITS'(value), data);
	endtask

	task automatic check_registers();
		logic [PIO_NBITS-1:0] data;
		read_reg(BM_FREEB_INIT, {model_init_done, 31'd0}, '1, 1'b1, data);
		read_reg(BM_FREEB_RD_COUNT, n_pop % BUF_NUM, '1, 1'b1, data);
		read_reg(BM_FREEB_WR_COUNT, n_push % BUF_NUM, '1, 1'b1, data);
		read_reg(BM_LL_RD_COUNT, n_link_rd % BUF_NUM, '1, 1'b1, data);
		read_reg(BM_LL_WR_COUNT, n_link_wr % BUF_NUM, '1, 1'b1, data);
		read_reg(BM_DT_ALPHA, alpha, '1, 1'b1, data);
	endtask

	// the fill leaves ids 0 to 31 on the stack with 31 on top and empties the queue.
	task automatic run_init();
		logic [PIO_NBITS-1:0] data;
		int start;
		init_started = 1'b1;
		pio_access(1'b1, BM_FREEB_INIT, 32'd1, data);
		start = cycle_count;
		data = '0;
		while (!data[31] && cycle_count - start < 2 * INIT_CYCLES)
			read_reg(BM_FREEB_INIT, '0, 32'h7fff_ffff, 1'b1, data);
		assert (data[31] && cycle_count - start <= INIT_CYCLES)
			else report_mismatch("init_done did not rise within 40 cycles");
		free_stack.delete();
		model_q.delete();
		for (int i = 0; i < BUF_NUM; i++)
			free_stack.push_back(BUF_PTR_NBITS'(i));
		model_init_done = 1'b1;
	endtask

	task automatic send_cmd(input bm_op_e op);
		bm_resp_t exp;
		int free_n;
		exp = '0;
		exp.valid = 1'b1;
		exp.op = op;
		if (op == BM_OP_ALLOC) begin
			free_n = free_stack.size();
			if (free_n != 0 && model_q.size() < (free_n * alpha) / 4) begin
				exp.granted = 1'b1;
				exp.buf_id = free_stack.pop_back();
				model_q.push_back(exp.buf_id);
				n_pop++;
				n_link_wr++;
			end
		end else if (model_q.size() != 0) begin
			exp.granted = 1'b1;
			exp.buf_id = model_q.pop_front(); // the head leaves first.
			free_stack.push_back(exp.buf_id);
			n_push++;
			n_link_rd++;
		end
		exp_resp = exp;
		resp_open = 1'b1;
		n_checks++;
		while (!cmd_ready)
			step();
		cmd = '{valid: 1'b1, op: op};
		step();
		cmd = '0;
		while (!resp.valid)
			step();
		step();
		resp_open = 1'b0;
	endtask

	task automatic end_test(input string name);
		n_tests++;
		$display("test %0d, %s: %0d errors", n_tests, name, n_errors - test_err_start);
		test_err_start = n_errors;
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------

	initial begin
		logic [PIO_NBITS-1:0] data;
		rst_n = 1'b0;
		reg_bs = 1'b0;
		reg_rd = 1'b0;
		reg_wr = 1'b0;
		reg_addr = '0;
		reg_din = '0;
		cmd = '0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		step();

		cmd = '{valid: 1'b1, op: BM_OP_ALLOC}; // must not be taken before init.
		repeat (4) step();
		cmd = '0;
		check_registers();
		end_test("reset values");

		run_init();
		write_alpha(15);
		repeat (BUF_NUM) send_cmd(BM_OP_ALLOC);
		end_test("init and allocation");

		repeat (BUF_NUM + 1) send_cmd(BM_OP_RELEASE);
		end_test("release order");

		write_alpha(4);
		repeat (20) send_cmd(BM_OP_ALLOC);
		write_alpha(0);
		repeat (4) send_cmd(BM_OP_ALLOC);
		end_test("dynamic threshold");

		write_alpha(8);
		for (int i = 0; i < 200; i++) begin
			lfsr = lfsr_step(lfsr);
			send_cmd(bm_op_e'(lfsr[0]));
		end
		check_registers();
		end_test("random mix and counters");

		div_slow = 1'b1;
		check_registers();
		read_reg(3'd6, '0, '1, 1'b0, data);
		read_reg(3'd7, '0, '1, 1'b0, data);
		div_slow = 1'b0;
		end_test("slow bus");

		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
verilog/bm_pkg.sv
verilog/bm_reg.sv
verilog/bm_freeb.sv
verilog/bm_ll.sv
verilog/bm_alloc.sv
verilog/bm_top.sv
dv/tb_bm.sv

// ==== Makefile ====
TOP = tb_bm

.PHONY: all run lint clean

all: run

obj_dir/sim: tb.f verilog/*.sv dv/*.sv
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o sim

run: obj_dir/sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)
	verilator --lint-only -Wall verilog/bm_pkg.sv verilog/bm_reg.sv verilog/bm_freeb.sv \
		verilog/bm_ll.sv verilog/bm_alloc.sv verilog/bm_top.sv --top-module bm_top

clean:
	rm -rf obj_dir
